// ==== core_cfg_pkg.sv ====
// ------------------------------
// Memory geometry, fixed program addresses
// and the control state encoding
// ------------------------------
package core_cfg_pkg;

  // Shared SRAM, 4KB of words
  localparam int MEM_WORDS = 1024;
  localparam int ADDR_W    = 10;

  // Program start after each start pulse
  localparam logic [31:0] RESET_PC = 32'd0;

  // Data slots used by the loop programs
  // n lives just below the result word
  localparam logic [31:0] ARG_ADDR    = 32'd956;
  // Word 240
  localparam logic [31:0] RESULT_ADDR = 32'd960;

  // Multi-cycle sequencing states
  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    DECODE,
    EXEC,
    MEM,
    WB,
    HALT
  } ctrl_state_e;

endpackage

// ==== rv_isa_pkg.sv ====
// ------------------------------
// RV32 subset encodings: opcodes, funct fields,
// ALU operations and field widths
// ------------------------------
package rv_isa_pkg;

  // Widths ---------------------------
  localparam int XLEN      = 32;
  localparam int REG_IDX_W = 5;
  localparam int OPCODE_W  = 7;
  localparam int FUNCT3_W  = 3;
  localparam int FUNCT7_W  = 7;
  // Shift amount, low bits of rs2 or imm
  localparam int SHAMT_W   = 5;

  // Major opcodes of the supported subset
  typedef enum logic [OPCODE_W-1:0] {
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011
  } opcode_e;

  // funct3 selectors ----------------
  localparam logic [FUNCT3_W-1:0] F3_SLL = 3'b001;
  localparam logic [FUNCT3_W-1:0] F3_BEQ = 3'b000;
  localparam logic [FUNCT3_W-1:0] F3_BNE = 3'b001;
  localparam logic [FUNCT3_W-1:0] F3_BLT = 3'b100;

  // funct7 that turns ADD into SUB
  localparam logic [FUNCT7_W-1:0] F7_SUB = 7'b0100000;

  // ALU operations
  // EQ, NE and LT only raise cond
  typedef enum logic [2:0] {
    ADD,
    SUB,
    SLL,
    EQ,
    NE,
    LT
  } alu_op_e;

endpackage

// ==== mem_bus_if.sv ====
// ------------------------------
// One req/ack memory port
// ------------------------------
interface mem_bus_if;

  // Request side, held until ack
  logic                       req;
  logic [rv_isa_pkg::XLEN-1:0] addr;
  logic [rv_isa_pkg::XLEN-1:0] wdata;
  logic                       wr_en;
  logic [3:0]                 mask;

  // Response side, ack is a single cycle
  // rdata valid together with ack
  logic                       ack;
  logic [rv_isa_pkg::XLEN-1:0] rdata;

  modport master (
    output req, addr, wdata, wr_en, mask,
    input  ack, rdata
  );

  modport slave (
    input  req, addr, wdata, wr_en, mask,
    output ack, rdata
  );

endinterface

// ==== pc_counter.sv ====
// ------------------------------
// Program counter, sequential and taken paths
// ------------------------------
module pc_counter (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        start,
  input  logic                        advance,
  input  logic                        take,
  input  logic [rv_isa_pkg::XLEN-1:0] target,
  output logic [rv_isa_pkg::XLEN-1:0] pc
);

  logic [rv_isa_pkg::XLEN-1:0] pc_seq;

  // Next sequential instruction
  assign pc_seq = pc + 32'd4;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= core_cfg_pkg::RESET_PC;
    end else if (start) begin
      // Every run begins at the program start
      pc <= core_cfg_pkg::RESET_PC;
    end else if (advance) begin
      // Branch or jump target, else fall through
      pc <= take ? target : pc_seq;
    end
  end

  // Fetch addresses stay on word boundaries
  a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
    pc[1:0] == 2'b00);

endmodule

// ==== reg_file.sv ====
// ------------------------------
// 32 x XLEN register file, x0 reads zero
// ------------------------------
module reg_file (
  input  logic                             clk,
  input  logic [rv_isa_pkg::REG_IDX_W-1:0] rs1,
  input  logic [rv_isa_pkg::REG_IDX_W-1:0] rs2,
  input  logic [rv_isa_pkg::REG_IDX_W-1:0] rd,
  input  logic                             wr_en,
  input  logic [rv_isa_pkg::XLEN-1:0]      wdata,
  output logic [rv_isa_pkg::XLEN-1:0]      rdata1,
  output logic [rv_isa_pkg::XLEN-1:0]      rdata2
);

  logic [rv_isa_pkg::XLEN-1:0] regs [2**rv_isa_pkg::REG_IDX_W];

  // Single write port
  // x0 is never written
  always_ff @(posedge clk) begin
    if (wr_en && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // Two combinational read ports
  assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== alu_unit.sv ====
// ------------------------------
// ALU: add, sub, shift left, branch compares
// ------------------------------
module alu_unit (
  input  rv_isa_pkg::alu_op_e         op,
  input  logic [rv_isa_pkg::XLEN-1:0] a,
  input  logic [rv_isa_pkg::XLEN-1:0] b,
  output logic [rv_isa_pkg::XLEN-1:0] result,
  output logic                        cond
);

  logic is_eq, is_lt;

  // Shared comparators
  assign is_eq = (a == b);
  // Signed, as for BLT
  assign is_lt = ($signed(a) < $signed(b));

  always_comb begin
    result = '0;
    cond   = 1'b0;
    case (op)
      rv_isa_pkg::ADD: result = a + b;
      rv_isa_pkg::SUB: result = a - b;
      // Only the low shamt bits count
      rv_isa_pkg::SLL: result = a << b[rv_isa_pkg::SHAMT_W-1:0];
      rv_isa_pkg::EQ:  cond   = is_eq;
      rv_isa_pkg::NE:  cond   = !is_eq;
      rv_isa_pkg::LT:  cond   = is_lt;
      default: ;
    endcase
  end

endmodule

// ==== core_ctrl_fsm.sv ====
// ------------------------------
// Multi-cycle RV32 subset core: control FSM,
// decode, immediates and datapath steering
// ------------------------------
module core_ctrl_fsm (
  input  logic      clk,
  input  logic      rst,
  input  logic      start,
  output logic      halted,
  mem_bus_if.master ibus,
  mem_bus_if.master dbus
);

  core_cfg_pkg::ctrl_state_e state, state_nxt;

  // Latched instruction and operands
  logic [rv_isa_pkg::XLEN-1:0] ir;
  logic [rv_isa_pkg::XLEN-1:0] rs1_val_q, rs2_val_q, imm_q, load_q;
  rv_isa_pkg::alu_op_e         alu_op_q;

  // Decode
  rv_isa_pkg::opcode_e               opcode;
  logic [rv_isa_pkg::FUNCT3_W-1:0]   funct3;
  logic [rv_isa_pkg::XLEN-1:0]       imm_i, imm_s, imm_b, imm_j, imm_sel;
  rv_isa_pkg::alu_op_e               alu_op_sel;

  // Datapath
  logic [rv_isa_pkg::XLEN-1:0] pc, target, alu_a, alu_b, alu_result;
  logic [rv_isa_pkg::XLEN-1:0] rdata1, rdata2, rf_wdata;
  logic alu_cond, start_ok, pc_advance, pc_take, rf_wr_en, self_jump;

  // Field extraction ----------------
  assign opcode = rv_isa_pkg::opcode_e'(ir[rv_isa_pkg::OPCODE_W-1:0]);
  assign funct3 = ir[14:12];

  // Sign extended immediates, B and J are even
  assign imm_i = {{20{ir[31]}}, ir[31:20]};
  assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
  assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
  assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

  // Immediate and ALU op per opcode
  always_comb begin
    imm_sel    = imm_i;
    alu_op_sel = rv_isa_pkg::ADD;
    case (opcode)
      rv_isa_pkg::OP: begin
        if (funct3 == rv_isa_pkg::F3_SLL) begin
          alu_op_sel = rv_isa_pkg::SLL;
        end else if (ir[31:25] == rv_isa_pkg::F7_SUB) begin
          alu_op_sel = rv_isa_pkg::SUB;
        end
      end
      rv_isa_pkg::BRANCH: begin
        imm_sel = imm_b;
        case (funct3)
          rv_isa_pkg::F3_BEQ: alu_op_sel = rv_isa_pkg::EQ;
          rv_isa_pkg::F3_BNE: alu_op_sel = rv_isa_pkg::NE;
          default:            alu_op_sel = rv_isa_pkg::LT;
        endcase
      end
      rv_isa_pkg::JAL:   imm_sel = imm_j;
      rv_isa_pkg::STORE: imm_sel = imm_s;
      // OP_IMM and LOAD use the I immediate with ADD
      default: ;
    endcase
  end

  // Payload registers, no reset
  always_ff @(posedge clk) begin
    if (state == core_cfg_pkg::FETCH && ibus.ack) begin
      ir <= ibus.rdata;
    end
    if (state == core_cfg_pkg::DECODE) begin
      rs1_val_q <= rdata1;
      rs2_val_q <= rdata2;
      imm_q     <= imm_sel;
      alu_op_q  <= alu_op_sel;
    end
    if (state == core_cfg_pkg::MEM && dbus.ack) begin
      load_q <= dbus.rdata;
    end
  end

  // Control FSM ---------------------
  assign start_ok  = start && (state == core_cfg_pkg::IDLE || state == core_cfg_pkg::HALT);
  // A jump onto itself ends the program
  assign self_jump = (opcode == rv_isa_pkg::JAL) && (imm_q == '0);

  always_comb begin
    state_nxt = state;
    case (state)
      core_cfg_pkg::IDLE, core_cfg_pkg::HALT: begin
        if (start_ok) state_nxt = core_cfg_pkg::FETCH;
      end
      core_cfg_pkg::FETCH: begin
        if (ibus.ack) state_nxt = core_cfg_pkg::DECODE;
      end
      core_cfg_pkg::DECODE: begin
        // Loads and stores skip EXEC, address comes from the ALU in MEM
        if (opcode == rv_isa_pkg::LOAD || opcode == rv_isa_pkg::STORE) begin
          state_nxt = core_cfg_pkg::MEM;
        end else begin
          state_nxt = core_cfg_pkg::EXEC;
        end
      end
      core_cfg_pkg::EXEC: begin
        state_nxt = self_jump ? core_cfg_pkg::HALT : core_cfg_pkg::FETCH;
      end
      core_cfg_pkg::MEM: begin
        if (dbus.ack) begin
          state_nxt = (opcode == rv_isa_pkg::LOAD) ? core_cfg_pkg::WB : core_cfg_pkg::FETCH;
        end
      end
      core_cfg_pkg::WB: state_nxt = core_cfg_pkg::FETCH;
      default:          state_nxt = core_cfg_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= core_cfg_pkg::IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  assign halted = (state == core_cfg_pkg::HALT);

  // Steering ------------------------
  // JAL links pc+4 through the ALU
  assign alu_a = (opcode == rv_isa_pkg::JAL) ? pc : rs1_val_q;
  always_comb begin
    case (opcode)
      rv_isa_pkg::OP, rv_isa_pkg::BRANCH: alu_b = rs2_val_q;
      rv_isa_pkg::JAL:                    alu_b = 32'd4;
      default:                            alu_b = imm_q;
    endcase
  end

  assign target     = pc + imm_q;
  assign pc_take    = (opcode == rv_isa_pkg::JAL) || (opcode == rv_isa_pkg::BRANCH && alu_cond);
  assign pc_advance = (state == core_cfg_pkg::EXEC && !self_jump) ||
                      (state == core_cfg_pkg::MEM && dbus.ack && opcode == rv_isa_pkg::STORE) ||
                      (state == core_cfg_pkg::WB);

  assign rf_wr_en = (state == core_cfg_pkg::WB) ||
                    (state == core_cfg_pkg::EXEC && (opcode == rv_isa_pkg::OP_IMM ||
                     opcode == rv_isa_pkg::OP || opcode == rv_isa_pkg::JAL));
  assign rf_wdata = (state == core_cfg_pkg::WB) ? load_q : alu_result;

  // Bus requests
  // Fetch never writes
  assign ibus.req   = (state == core_cfg_pkg::FETCH);
  assign ibus.addr  = pc;
  assign ibus.wdata = '0;
  assign ibus.wr_en = 1'b0;
  assign ibus.mask  = 4'h0;

  // Word accesses only
  assign dbus.req   = (state == core_cfg_pkg::MEM);
  assign dbus.addr  = alu_result;
  assign dbus.wdata = rs2_val_q;
  assign dbus.wr_en = (opcode == rv_isa_pkg::STORE);
  assign dbus.mask  = 4'hF;

  pc_counter pc_counter_i (
    .clk    (clk),
    .rst    (rst),
    .start  (start_ok),
    .advance(pc_advance),
    .take   (pc_take),
    .target (target),
    .pc     (pc)
  );

  reg_file reg_file_i (
    .clk   (clk),
    .rs1   (ir[19:15]),
    .rs2   (ir[24:20]),
    .rd    (ir[11:7]),
    .wr_en (rf_wr_en),
    .wdata (rf_wdata),
    .rdata1(rdata1),
    .rdata2(rdata2)
  );

  alu_unit alu_unit_i (
    .op    (alu_op_q),
    .a     (alu_a),
    .b     (alu_b),
    .result(alu_result),
    .cond  (alu_cond)
  );

  // Checks --------------------------
  a_state_valid: assert property (@(posedge clk) disable iff (rst)
    state inside {core_cfg_pkg::IDLE, core_cfg_pkg::FETCH, core_cfg_pkg::DECODE,
                  core_cfg_pkg::EXEC, core_cfg_pkg::MEM, core_cfg_pkg::WB,
                  core_cfg_pkg::HALT});

  a_one_master: assert property (@(posedge clk) disable iff (rst)
    !(ibus.req && dbus.req));

endmodule

// ==== mem_arbiter.sv ====
// ------------------------------
// Fixed priority arbiter: data, fetch, host
// onto the single SRAM port
// ------------------------------
module mem_arbiter (
  input  logic                        clk,
  input  logic                        rst,
  mem_bus_if.slave                    ibus,
  mem_bus_if.slave                    dbus,
  mem_bus_if.master                   sbus,
  input  logic                        host_req,
  input  logic                        host_wr_en,
  input  logic [rv_isa_pkg::XLEN-1:0] host_addr,
  input  logic [rv_isa_pkg::XLEN-1:0] host_wdata,
  output logic [rv_isa_pkg::XLEN-1:0] host_rdata,
  output logic                        host_ack
);

  logic sel_d, sel_i, sel_h;
  logic gnt_d_q, gnt_i_q, gnt_h_q;
  logic busy;

  // Ack cycle of the last grant
  // winner still holds req here, so no new grant
  assign busy  = gnt_d_q || gnt_i_q || gnt_h_q;
  assign sel_d = dbus.req && !busy;
  assign sel_i = ibus.req && !dbus.req && !busy;
  assign sel_h = host_req && !ibus.req && !dbus.req && !busy;

  // SRAM port mux
  always_comb begin
    sbus.req   = sel_d || sel_i || sel_h;
    sbus.addr  = host_addr;
    sbus.wdata = host_wdata;
    sbus.wr_en = sel_h && host_wr_en;
    sbus.mask  = 4'hF;
    if (sel_d) begin
      sbus.addr  = dbus.addr;
      sbus.wdata = dbus.wdata;
      sbus.wr_en = dbus.wr_en;
      sbus.mask  = dbus.mask;
    end else if (sel_i) begin
      // Fetch is a pure read
      sbus.addr  = ibus.addr;
      sbus.wdata = ibus.wdata;
      sbus.wr_en = 1'b0;
      sbus.mask  = 4'h0;
    end
  end

  // Remember the winner for the response
  always_ff @(posedge clk) begin
    if (rst) begin
      gnt_d_q <= 1'b0;
      gnt_i_q <= 1'b0;
      gnt_h_q <= 1'b0;
    end else begin
      gnt_d_q <= sel_d;
      gnt_i_q <= sel_i;
      gnt_h_q <= sel_h;
    end
  end

  // Route response to the granted requester
  assign dbus.ack   = gnt_d_q && sbus.ack;
  assign ibus.ack   = gnt_i_q && sbus.ack;
  assign host_ack   = gnt_h_q && sbus.ack;
  assign dbus.rdata = sbus.rdata;
  assign ibus.rdata = sbus.rdata;
  assign host_rdata = sbus.rdata;

  a_one_ack: assert property (@(posedge clk) disable iff (rst)
    $onehot0({dbus.ack, ibus.ack, host_ack}));

  // SRAM answers every grant exactly one cycle later
  a_sram_ack: assert property (@(posedge clk) disable iff (rst)
    sbus.ack == busy);

endmodule

// ==== sram_model.sv ====
// ------------------------------
// Single-port word SRAM, registered read,
// byte masked write
// ------------------------------
module sram_model #(
  parameter int WORDS = 1024,
  parameter int AW    = 10,
  parameter int DW    = 32
) (
  input logic      clk,
  mem_bus_if.slave bus
);

  logic [DW-1:0] mem [WORDS];
  logic [AW-1:0] widx;

  // Byte address to word index
  assign widx = bus.addr[AW+1:2];

  always_ff @(posedge clk) begin
    // Response always one cycle after the enable
    bus.ack <= bus.req;
    if (bus.req) begin
      for (int b = 0; b < DW/8; b++) begin
        if (bus.wr_en && bus.mask[b]) begin
          mem[widx][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
      // Read returns the old word on a write
      bus.rdata <= mem[widx];
    end
  end

endmodule

// ==== core_sys.sv ====
// ------------------------------
// Top level: core, arbiter and SRAM
// ------------------------------
module core_sys (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        start,
  output logic                        halted,
  input  logic                        host_req,
  input  logic                        host_wr_en,
  input  logic [rv_isa_pkg::XLEN-1:0] host_addr,
  input  logic [rv_isa_pkg::XLEN-1:0] host_wdata,
  output logic [rv_isa_pkg::XLEN-1:0] host_rdata,
  output logic                        host_ack
);

  // Fetch, data and SRAM ports
  mem_bus_if ibus ();
  mem_bus_if dbus ();
  mem_bus_if sbus ();

  core_ctrl_fsm core_ctrl_fsm_i (
    .clk   (clk),
    .rst   (rst),
    .start (start),
    .halted(halted),
    .ibus  (ibus),
    .dbus  (dbus)
  );

  mem_arbiter mem_arbiter_i (
    .clk       (clk),
    .rst       (rst),
    .ibus      (ibus),
    .dbus      (dbus),
    .sbus      (sbus),
    .host_req  (host_req),
    .host_wr_en(host_wr_en),
    .host_addr (host_addr),
    .host_wdata(host_wdata),
    .host_rdata(host_rdata),
    .host_ack  (host_ack)
  );

  sram_model #(
    .WORDS(core_cfg_pkg::MEM_WORDS),
    .AW   (core_cfg_pkg::ADDR_W),
    .DW   (rv_isa_pkg::XLEN)
  ) sram_model_i (
    .clk(clk),
    .bus(sbus)
  );

  // Host loads and reads only while the core is parked
  a_host_idle: assert property (@(posedge clk) disable iff (rst)
    host_req |-> core_ctrl_fsm_i.state inside {core_cfg_pkg::IDLE, core_cfg_pkg::HALT});

endmodule

// ==== tb_asm.svh ====
// ------------------------------
// RV32 instruction encoders and the
// doubler and Fibonacci program images
// ------------------------------
`ifndef TB_ASM_SVH
`define TB_ASM_SVH

// Word access funct3 for LW and SW
localparam logic [2:0] F3_WORD = 3'b010;
localparam logic [2:0] F3_ADD  = 3'b000;
localparam int DBL_LEN = 8;
localparam int FIB_LEN = 14;

// Format encoders, arguments in ISA field order
function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input rv_isa_pkg::opcode_e op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OP};
endfunction

function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
  return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], rv_isa_pkg::STORE};
endfunction

// Branch offset in bytes, bit 0 dropped
function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::BRANCH};
endfunction

function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::JAL};
endfunction

// Doubler: x2 = 2**n by repeated x2 + x2
function automatic logic [31:0] doubler_word(input int idx);
  case (idx)
    0: return i_type(12'(core_cfg_pkg::ARG_ADDR), 5'd0, F3_WORD, 5'd1, rv_isa_pkg::LOAD);
    1: return i_type(12'd1, 5'd0, F3_ADD, 5'd2, rv_isa_pkg::OP_IMM);
    2: return i_type(12'd0, 5'd0, F3_ADD, 5'd3, rv_isa_pkg::OP_IMM);
    3: return r_type(7'd0, 5'd2, 5'd2, F3_ADD, 5'd2);
    4: return i_type(12'd1, 5'd3, F3_ADD, 5'd3, rv_isa_pkg::OP_IMM);
    // Back to the add at byte 12
    5: return b_type(-13'sd8, 5'd1, 5'd3, rv_isa_pkg::F3_BNE);
    6: return s_type(12'(core_cfg_pkg::RESULT_ADDR), 5'd2, 5'd0);
    default: return j_type(21'd0, 5'd0);
  endcase
endfunction

// Fibonacci: count x1 down with SUB, result address built with SLL
function automatic logic [31:0] fib_word(input int idx);
  case (idx)
    0:  return i_type(12'(core_cfg_pkg::ARG_ADDR), 5'd0, F3_WORD, 5'd1, rv_isa_pkg::LOAD);
    1:  return i_type(12'd0, 5'd0, F3_ADD, 5'd2, rv_isa_pkg::OP_IMM);
    2:  return i_type(12'd1, 5'd0, F3_ADD, 5'd3, rv_isa_pkg::OP_IMM);
    3:  return i_type(12'd1, 5'd0, F3_ADD, 5'd5, rv_isa_pkg::OP_IMM);
    4:  return r_type(7'd0, 5'd3, 5'd2, F3_ADD, 5'd4);
    5:  return r_type(7'd0, 5'd0, 5'd3, F3_ADD, 5'd2);
    6:  return r_type(7'd0, 5'd0, 5'd4, F3_ADD, 5'd3);
    7:  return r_type(rv_isa_pkg::F7_SUB, 5'd5, 5'd1, F3_ADD, 5'd1);
    // Loop while 0 < x1
    8:  return b_type(-13'sd16, 5'd1, 5'd0, rv_isa_pkg::F3_BLT);
    9:  return i_type(12'd240, 5'd0, F3_ADD, 5'd6, rv_isa_pkg::OP_IMM);
    10: return i_type(12'd2, 5'd0, F3_ADD, 5'd7, rv_isa_pkg::OP_IMM);
    11: return r_type(7'd0, 5'd7, 5'd6, rv_isa_pkg::F3_SLL, 5'd6);
    12: return s_type(12'd0, 5'd4, 5'd6);
    default: return j_type(21'd0, 5'd0);
  endcase
endfunction

`endif

// ==== core_sys_tb.sv ====
// ------------------------------
// Testbench for core_sys: host loads, program
// runs from a table, result and memory checks
// ------------------------------
module core_sys_tb;
  timeunit 1ns;
  timeprecision 100ps;

  `include "tb_asm.svh"

  localparam time CLK_PERIOD = 100ns;
  localparam time DRIVE_DLY  = 5ns;
  localparam int  NUM_ROWS   = 6;
  localparam int  N_MAX      = 30;
  // Untouched words around the argument and result slots
  localparam int  SENT_FIRST = 900;
  localparam int  SENT_LAST  = 1020;

  typedef enum logic {PROG_DBL, PROG_FIB} prog_e;

  logic clk, rst, start, halted;
  logic host_req, host_wr_en, host_ack;
  logic [rv_isa_pkg::XLEN-1:0] host_addr, host_wdata, host_rdata;

  // Stimulus table ------------------
  // n and expected value filled in after seeding
  string row_name [NUM_ROWS] = '{"doubler_a", "fib_a", "doubler_b",
                                 "fib_b", "fib_c", "doubler_c"};
  prog_e row_prog [NUM_ROWS] = '{PROG_DBL, PROG_FIB, PROG_DBL,
                                 PROG_FIB, PROG_FIB, PROG_DBL};
  int unsigned                 row_n   [NUM_ROWS];
  logic [rv_isa_pkg::XLEN-1:0] row_exp [NUM_ROWS];

  int          halt_rises  = 0;
  logic        halted_prev = 1'b0;

  core_sys core_sys_i (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .halted    (halted),
    .host_req  (host_req),
    .host_wr_en(host_wr_en),
    .host_addr (host_addr),
    .host_wdata(host_wdata),
    .host_rdata(host_rdata),
    .host_ack  (host_ack)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Per row up to N_MAX loop steps, 40 instructions each at 6 cycles
  initial begin
    #((NUM_ROWS + 1) * N_MAX * 40 * 6 * CLK_PERIOD);
    $display("Timeout: the core never halted within the expected run time");
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

  // Rising edges of halted, sampled mid-cycle
  always @(negedge clk) begin
    if (halted === 1'b1 && halted_prev !== 1'b1) begin
      halt_rises++;
    end
    halted_prev = halted;
  end

  // Reference models ----------------
  function automatic logic [31:0] pow2_ref(input int unsigned n);
    logic [31:0] r;
    r = 32'd1;
    // Doubling wraps at 32 bits
    repeat (n) r = r + r;
    return r;
  endfunction

  function automatic logic [31:0] fib_ref(input int unsigned n);
    logic [31:0] a, b, c;
    a = 32'd0;
    b = 32'd1;
    c = 32'd0;
    repeat (n) begin
      c = a + b;
      a = b;
      b = c;
    end
    return c;
  endfunction

  // Mixes every address bit
  function automatic logic [31:0] pattern_at(input logic [31:0] addr);
    return (addr * 32'h9E37_79B1) ^ 32'h5A3C_C3A5;
  endfunction

  // Compare tasks -------------------
  task automatic check_word(input string name, input logic [rv_isa_pkg::XLEN-1:0] exp,
                            input logic [rv_isa_pkg::XLEN-1:0] act);
    if (act !== exp) begin
      $display("** Error [%s] expected %h, actual %h", name, exp, act);
      $display("Test failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error [%s] expected %b, actual %b", name, exp, act);
      $display("Test failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // Host port -----------------------
  // Hold req and fields until ack, then release
  task automatic bus_cycle(input logic wr, input logic [31:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    @(posedge clk);
    #DRIVE_DLY;
    host_req   = 1'b1;
    host_wr_en = wr;
    host_addr  = addr;
    host_wdata = wdata;
    @(negedge clk);
    // No ack in the grant cycle
    check_flag("host ack in grant cycle", 1'b0, host_ack);
    @(negedge clk);
    while (host_ack !== 1'b1) @(negedge clk);
    rdata = host_rdata;
    @(posedge clk);
    #DRIVE_DLY;
    host_req   = 1'b0;
    host_wr_en = 1'b0;
  endtask

  task automatic write_mem(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    bus_cycle(1'b1, addr, data, unused);
  endtask

  task automatic read_mem(input logic [31:0] addr, output logic [31:0] data);
    bus_cycle(1'b0, addr, 32'd0, data);
  endtask

  task automatic load_program(input prog_e p);
    int len;
    len = (p == PROG_DBL) ? DBL_LEN : FIB_LEN;
    for (int idx = 0; idx < len; idx++) begin
      write_mem(32'(idx * 4), (p == PROG_DBL) ? doubler_word(idx) : fib_word(idx));
    end
  endtask

  task automatic fill_sentinels();
    for (int a = SENT_FIRST; a <= SENT_LAST; a += 4) begin
      if (a != core_cfg_pkg::ARG_ADDR && a != core_cfg_pkg::RESULT_ADDR) begin
        write_mem(32'(a), pattern_at(32'(a)));
      end
    end
  endtask

  task automatic verify_sentinels(input string name);
    logic [31:0] word;
    for (int a = SENT_FIRST; a <= SENT_LAST; a += 4) begin
      if (a != core_cfg_pkg::ARG_ADDR && a != core_cfg_pkg::RESULT_ADDR) begin
        read_mem(32'(a), word);
        check_word($sformatf("%s word %0d", name, a), pattern_at(32'(a)), word);
      end
    end
  endtask

  task automatic pulse_start();
    @(posedge clk);
    #DRIVE_DLY;
    start = 1'b1;
    @(posedge clk);
    #DRIVE_DLY;
    start = 1'b0;
  endtask

  // One table row -------------------
  task automatic run_row(input int i);
    logic [31:0] word;
    load_program(row_prog[i]);
    write_mem(core_cfg_pkg::ARG_ADDR, 32'(row_n[i]));
    // Stale result must not pass
    write_mem(core_cfg_pkg::RESULT_ADDR, pattern_at(core_cfg_pkg::RESULT_ADDR));
    pulse_start();
    @(negedge clk);
    check_flag({row_name[i], " halted after start"}, 1'b0, halted);
    while (halted !== 1'b1) @(negedge clk);
    read_mem(core_cfg_pkg::RESULT_ADDR, word);
    check_word({row_name[i], " result"}, row_exp[i], word);
    verify_sentinels(row_name[i]);
    // Still parked after the host traffic, one rise per run
    @(negedge clk);
    check_flag({row_name[i], " halted held"}, 1'b1, halted);
    check_word({row_name[i], " halt count"}, 32'(i + 1), 32'(halt_rises));
  endtask

  // Main sequence -------------------
  initial begin
    rst        = 1'b1;
    start      = 1'b0;
    host_req   = 1'b0;
    host_wr_en = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    void'($urandom(33365));
    for (int i = 0; i < NUM_ROWS; i++) begin
      row_n[i]   = 1 + ($urandom % N_MAX);
      row_exp[i] = (row_prog[i] == PROG_DBL) ? pow2_ref(row_n[i]) : fib_ref(row_n[i]);
    end
    repeat (2) @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b0;
    // Core idle, host alone on the SRAM
    @(negedge clk);
    check_flag("reset halted", 1'b0, halted);
    check_flag("reset host ack", 1'b0, host_ack);
    fill_sentinels();
    verify_sentinels("host readback");
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i);
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== core_sys.f ====
+incdir+.
core_cfg_pkg.sv
rv_isa_pkg.sv
mem_bus_if.sv
pc_counter.sv
reg_file.sv
alu_unit.sv
core_ctrl_fsm.sv
mem_arbiter.sv
sram_model.sv
core_sys.sv
core_sys_tb.sv
